// File: Bender.yml
package:
  name: edge_fetch

sources:
  - rtl/edge_fetch_pkg.sv
  - rtl/edge_sync_fifo.sv
  - rtl/edge_chunk_planner.sv
  - rtl/edge_array_lane.sv
  - rtl/mem_read_arbiter.sv
  - rtl/edge_assembler.sv
  - rtl/edge_fetch_top.sv
  - target: simulation
    files:
      - dv/edge_mem_model.sv
      - dv/edge_fetch_tb.sv

// File: compile.f
rtl/edge_fetch_pkg.sv
rtl/edge_sync_fifo.sv
rtl/edge_chunk_planner.sv
rtl/edge_array_lane.sv
rtl/mem_read_arbiter.sv
rtl/edge_assembler.sv
rtl/edge_fetch_top.sv
dv/edge_mem_model.sv
dv/edge_fetch_tb.sv

// File: dv/edge_fetch_tb.sv
/*
 * Edge fetch engine testbench
 *   clock, reset and watchdog
 *   job driver, edge collector and value compare
 *   directed tests for aligned, misaligned and empty jobs,
 *   output back-pressure and back-to-back jobs under stalls
 */

`timescale 1ns/1ps

module edge_fetch_tb;

	import edge_fetch_pkg::*;

	localparam int    clock_period    = 40;
	localparam int    max_rand_degree = 40;
	localparam int    total_edges     = 16 + 40 + 5 + 50 + 4 * max_rand_degree;
	localparam int    watchdog_cycles = total_edges * 60 + 2000;
	localparam addr_t src_base        = 32'h1000_0000;
	localparam addr_t dest_base       = 32'h2000_0000;
	localparam addr_t weight_base     = 32'h3000_0000;

	logic        clock;
	logic        rstn;
	logic        job_valid;
	logic        job_ready;
	edge_index_t job_edge_index;
	edge_index_t job_degree;
	logic        mem_req_valid;
	logic        mem_req_ready;
	addr_t       mem_req_addr;
	tag_t        mem_req_tag;
	logic        mem_rsp_valid;
	tag_t        mem_rsp_tag;
	line_t       mem_rsp_data;
	logic        edge_valid;
	logic        edge_ready;
	elem_t       edge_src;
	elem_t       edge_dest;
	elem_t       edge_weight;
	edge_id_t    edge_id;
	int          stall_pct;
	edge_id_t    expected_id;
	elem_t       exp_src [$];
	elem_t       exp_dest [$];
	elem_t       exp_weight [$];

	edge_fetch_top edge_fetch_top_inst (
		.clock         (clock),
		.rstn          (rstn),
		.src_base      (src_base),
		.dest_base     (dest_base),
		.weight_base   (weight_base),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.job_edge_index(job_edge_index),
		.job_degree    (job_degree),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req_addr  (mem_req_addr),
		.mem_req_tag   (mem_req_tag),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_tag   (mem_rsp_tag),
		.mem_rsp_data  (mem_rsp_data),
		.edge_valid    (edge_valid),
		.edge_ready    (edge_ready),
		.edge_src      (edge_src),
		.edge_dest     (edge_dest),
		.edge_weight   (edge_weight),
		.edge_id       (edge_id)
	);

	edge_mem_model mem_model_inst (
		.clock        (clock),
		.rstn         (rstn),
		.stall_pct    (stall_pct),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_addr (mem_req_addr),
		.mem_req_tag  (mem_req_tag),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_tag  (mem_rsp_tag),
		.mem_rsp_data (mem_rsp_data)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout after %0d cycles, the edges never all arrived", watchdog_cycles);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////
	// Driver, collector and compare
	//////////////////////////////////////////////////

	task automatic check_value(input string test_name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s expected 0x%08h actual 0x%08h",
				test_name, field, expected, actual);
			$display("Some tests failed");
			$fatal(1, "value check failed");
		end
	endtask

	// Edge p of a job at index i reads element i+p of each array
	task automatic send_job(input int unsigned index, input int unsigned degree);
		for (int unsigned p = 0; p < degree; p++) begin
			exp_src.push_back(src_base + addr_t'(4 * (index + p)));
			exp_dest.push_back(dest_base + addr_t'(4 * (index + p)));
			exp_weight.push_back(weight_base + addr_t'(4 * (index + p)));
		end
		@(posedge clock);
		#1;
		job_valid      = 1'b1;
		job_edge_index = edge_index_t'(index);
		job_degree     = edge_index_t'(degree);
		@(posedge clock);
		while (!job_ready) begin
			@(posedge clock);
		end
		#1;
		job_valid = 1'b0;
	endtask

	task automatic collect_edges(input string test_name, input int n, input bit random_ready);
		int got;
		got = 0;
		while (got < n) begin
			@(posedge clock);
			if (edge_valid && edge_ready) begin
				check_value(test_name, $sformatf("edge %0d id", got), 32'(expected_id), 32'(edge_id));
				check_value(test_name, $sformatf("edge %0d src", got), exp_src.pop_front(), edge_src);
				check_value(test_name, $sformatf("edge %0d dest", got), exp_dest.pop_front(), edge_dest);
				check_value(test_name, $sformatf("edge %0d weight", got),
					exp_weight.pop_front(), edge_weight);
				expected_id++;
				got++;
			end
			#1;
			edge_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
		end
		edge_ready = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic aligned_job();
		fork
			send_job(32, 16);
			collect_edges("aligned", 16, 1'b0);
		join
	endtask

	// Chunks of 3, 16, 16 and 5 elements
	task automatic misaligned_job();
		fork
			send_job(13, 40);
			collect_edges("misaligned", 40, 1'b0);
		join
	endtask

	task automatic zero_degree_job();
		fork
			begin
				send_job(200, 0);
				send_job(77, 5);
			end
			collect_edges("zero_degree", 5, 1'b0);
		join
	endtask

	task automatic output_backpressure();
		fork
			send_job(150, 50);
			collect_edges("backpressure", 50, 1'b1);
		join
	endtask

	task automatic jobs_under_stalls();
		int unsigned index [4];
		int unsigned degree [4];
		int          total;
		total = 0;
		foreach (index[j]) begin
			index[j]  = $urandom_range(0, 4000);
			degree[j] = $urandom_range(1, max_rand_degree);
			total += degree[j];
		end
		stall_pct = 70;
		fork
			begin
				foreach (index[j]) begin
					send_job(index[j], degree[j]);
				end
			end
			collect_edges("back_to_back", total, 1'b0);
		join
		stall_pct = 25;
		@(posedge clock);
		check_value("back_to_back", "job_ready", 32'd1, 32'(job_ready));
	endtask

	// Nothing extra may come out once every job is done
	task automatic finish_checks();
		repeat (20) @(posedge clock);
		check_value("final", "edge_valid", 32'd0, 32'(edge_valid));
	endtask

	initial begin
		void'($urandom(99701));
		rstn           = 1'b0;
		job_valid      = 1'b0;
		job_edge_index = '0;
		job_degree     = '0;
		edge_ready     = 1'b1;
		stall_pct      = 25;
		expected_id    = '0;
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
		aligned_job();
		misaligned_job();
		zero_degree_job();
		output_backpressure();
		jobs_under_stalls();
		finish_checks();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: dv/edge_mem_model.sv
/*
 * Memory responder for the edge fetch engine
 *   random mem_req_ready stalls
 *   one read slot per tag, answered after 1 to 6 cycles
 *   ready slots picked in random order
 *   every element holds its own byte address
 */

`timescale 1ns/1ps

module edge_mem_model (
	input  logic                  clock,
	input  logic                  rstn,
	input  int                    stall_pct,
	input  logic                  mem_req_valid,
	output logic                  mem_req_ready,
	input  edge_fetch_pkg::addr_t mem_req_addr,
	input  edge_fetch_pkg::tag_t  mem_req_tag,
	output logic                  mem_rsp_valid,
	output edge_fetch_pkg::tag_t  mem_rsp_tag,
	output edge_fetch_pkg::line_t mem_rsp_data
);

	import edge_fetch_pkg::*;

	logic  pending [NUM_LANES];
	addr_t pend_addr [NUM_LANES];
	int    delay [NUM_LANES];

	// Element k of a line is its own byte address
	function automatic line_t line_at(input addr_t line_addr);
		line_t line;
		for (int k = 0; k < ELEMS_PER_LINE; k++) begin
			line[k*ELEM_W +: ELEM_W] = line_addr + addr_t'(k * ELEM_BYTES);
		end
		return line;
	endfunction

	initial begin
		int start;
		int idx;
		int pick;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_tag   = '0;
		mem_rsp_data  = '0;
		foreach (pending[i]) begin
			pending[i]   = 1'b0;
			pend_addr[i] = '0;
			delay[i]     = 0;
		end
		forever begin
			@(posedge clock);
			pick = -1;
			if (!rstn) begin
				foreach (pending[i]) begin
					pending[i] = 1'b0;
				end
			end else begin
				// Age the reads already in flight
				foreach (pending[i]) begin
					if (pending[i] && delay[i] > 0) begin
						delay[i]--;
					end
				end
				if (mem_req_valid && mem_req_ready) begin
					pending[mem_req_tag]   = 1'b1;
					pend_addr[mem_req_tag] = mem_req_addr;
					delay[mem_req_tag]     = $urandom_range(1, 6);
				end
				// Random starting slot gives out-of-order answers
				start = $urandom_range(0, NUM_LANES - 1);
				for (int k = 0; k < NUM_LANES; k++) begin
					idx = (start + k) % NUM_LANES;
					if (pick < 0 && pending[idx] && delay[idx] == 0) begin
						pick = idx;
					end
				end
				if (pick >= 0) begin
					pending[pick] = 1'b0;
				end
			end
			#1;
			mem_req_ready = rstn && ($urandom_range(0, 99) >= stall_pct);
			mem_rsp_valid = (pick >= 0);
			if (pick >= 0) begin
				mem_rsp_tag  = tag_t'(pick);
				mem_rsp_data = line_at(pend_addr[pick]);
			end
		end
	end

endmodule

// File: rtl/edge_array_lane.sv
/*
 * Array lane
 *   one line read per chunk from one edge array
 *   FSM through idle, request, wait and unpack
 *   element FIFO towards the assembler
 */

`timescale 1ns/1ps

module edge_array_lane #(
	parameter edge_fetch_pkg::tag_t lane_tag = edge_fetch_pkg::LANE_SRC
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  edge_fetch_pkg::addr_t               base_addr,
	input  logic                                chunk_valid,
	output logic                                chunk_ready,
	input  edge_fetch_pkg::edge_index_t         chunk_line,
	input  logic [edge_fetch_pkg::OFFSET_W-1:0] chunk_first,
	input  logic [edge_fetch_pkg::COUNT_W-1:0]  chunk_count,
	output logic                                req_valid,
	input  logic                                req_ready,
	output edge_fetch_pkg::addr_t               req_addr,
	input  logic                                rsp_valid,
	input  edge_fetch_pkg::line_t               rsp_data,
	output logic                                elem_valid,
	input  logic                                elem_ready,
	output edge_fetch_pkg::elem_t               elem_data
);

	import edge_fetch_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait,
		st_unpack
	} lane_state_t;

	lane_state_t         state;
	line_t               line_buf;
	logic [OFFSET_W-1:0] pos;
	logic [COUNT_W-1:0]  left;
	logic                push;
	logic                fifo_empty;

	// New chunk only once the previous one has fully drained
	assign chunk_ready = (state == st_idle) && fifo_empty;
	assign req_valid   = (state == st_request);
	assign push        = (state == st_unpack);
	assign elem_valid  = !fifo_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
			pos   <= '0;
			left  <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (chunk_valid) begin
						pos   <= chunk_first;
						left  <= chunk_count;
						state <= st_request;
					end
				end
				st_request: begin
					if (req_ready) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (rsp_valid) begin
						state <= st_unpack;
					end
				end
				st_unpack: begin
					pos  <= pos + 1'b1;
					left <= left - 1'b1;
					if (left == COUNT_W'(1)) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (chunk_valid && chunk_ready) begin
			req_addr <= base_addr + addr_t'(chunk_line) * addr_t'(LINE_BYTES);
		end
		if (state == st_wait && rsp_valid) begin
			line_buf <= rsp_data;
		end
	end

	edge_sync_fifo #(
		.payload_t(elem_t),
		.depth    (ELEMS_PER_LINE)
	) elem_fifo_inst (
		.clock    (clock),
		.rstn     (rstn),
		.push     (push),
		.push_data(line_buf[pos*ELEM_W +: ELEM_W]),
		.full     (),
		.pop      (elem_ready),
		.pop_data (elem_data),
		.empty    (fifo_empty)
	);

	// Arbiter routes a response here only for our own read
	assert property (@(posedge clock) disable iff (!rstn) rsp_valid |-> state == st_wait)
		else $error("lane %0d got a response outside wait", lane_tag);

endmodule

// File: rtl/edge_assembler.sv
/*
 * Edge assembler
 *   joins one element per lane into an edge
 *   running edge id across jobs
 *   output queue, first-word fall-through
 */

`timescale 1ns/1ps

module edge_assembler (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic [edge_fetch_pkg::NUM_LANES-1:0] elem_valid,
	input  edge_fetch_pkg::elem_t                elem_data [edge_fetch_pkg::NUM_LANES],
	output logic                                 elem_ready,
	output logic                                 edge_valid,
	input  logic                                 edge_ready,
	output edge_fetch_pkg::elem_t                edge_src,
	output edge_fetch_pkg::elem_t                edge_dest,
	output edge_fetch_pkg::elem_t                edge_weight,
	output edge_fetch_pkg::edge_id_t             edge_id
);

	import edge_fetch_pkg::*;

	logic     hold_valid;
	logic     hold_push;
	logic     fifo_full;
	logic     fifo_empty;
	edge_t    hold_edge;
	edge_t    head;
	edge_id_t next_id;

	// Held edge leaves this cycle unless the queue is full
	assign hold_push  = hold_valid && !fifo_full;
	assign elem_ready = (&elem_valid) && (!hold_valid || !fifo_full);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			hold_valid <= 1'b0;
			next_id    <= '0;
		end else if (elem_ready) begin
			hold_valid <= 1'b1;
			next_id    <= next_id + 1'b1;
		end else if (hold_push) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (elem_ready) begin
			hold_edge <= '{id: next_id, src: elem_data[LANE_SRC],
				dest: elem_data[LANE_DEST], weight: elem_data[LANE_WEIGHT]};
		end
	end

	edge_sync_fifo #(
		.payload_t(edge_t),
		.depth    (EDGE_FIFO_DEPTH)
	) edge_fifo_inst (
		.clock    (clock),
		.rstn     (rstn),
		.push     (hold_push),
		.push_data(hold_edge),
		.full     (fifo_full),
		.pop      (edge_valid && edge_ready),
		.pop_data (head),
		.empty    (fifo_empty)
	);

	assign edge_valid  = !fifo_empty;
	assign edge_id     = head.id;
	assign edge_src    = head.src;
	assign edge_dest   = head.dest;
	assign edge_weight = head.weight;

endmodule

// File: rtl/edge_chunk_planner.sv
/*
 * Chunk planner
 *   accepts vertex jobs (start index and degree)
 *   cuts the edge range into per-cacheline chunks
 *   first chunk shortened on a misaligned start
 */

`timescale 1ns/1ps

module edge_chunk_planner (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  logic                                      job_valid,
	output logic                                      job_ready,
	input  edge_fetch_pkg::edge_index_t               job_edge_index,
	input  edge_fetch_pkg::edge_index_t               job_degree,
	output logic                                      chunk_valid,
	input  logic                                      chunk_ready,
	output edge_fetch_pkg::edge_index_t               chunk_line,
	output logic [edge_fetch_pkg::OFFSET_W-1:0]       chunk_first,
	output logic [edge_fetch_pkg::COUNT_W-1:0]        chunk_count
);

	import edge_fetch_pkg::*;

	logic               job_go;
	logic               chunk_go;
	logic [COUNT_W-1:0] first_room;
	logic [COUNT_W-1:0] first_count;
	logic [COUNT_W-1:0] next_count;
	edge_index_t        remaining;

	// Idle whenever no chunk is pending
	assign job_ready = !chunk_valid;
	assign job_go    = job_valid && job_ready;
	assign chunk_go  = chunk_valid && chunk_ready;

	//////////////////////////////////////////////////
	// Chunk sizing
	//////////////////////////////////////////////////

	// Room left in the first line after the start offset
	assign first_room = COUNT_W'(ELEMS_PER_LINE) - COUNT_W'(job_edge_index[OFFSET_W-1:0]);

	assign first_count = (job_degree < edge_index_t'(first_room)) ?
		COUNT_W'(job_degree) : first_room;

	assign next_count = (remaining < edge_index_t'(ELEMS_PER_LINE)) ?
		COUNT_W'(remaining) : COUNT_W'(ELEMS_PER_LINE);

	//////////////////////////////////////////////////
	// Job and chunk state
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			chunk_valid <= 1'b0;
			remaining   <= '0;
		end else if (job_go) begin
			// Zero degree jobs finish here
			chunk_valid <= (job_degree != '0);
			remaining   <= job_degree - edge_index_t'(first_count);
		end else if (chunk_go) begin
			chunk_valid <= (remaining != '0);
			remaining   <= remaining - edge_index_t'(next_count);
		end
	end

	always_ff @(posedge clock) begin
		if (job_go) begin
			chunk_line  <= job_edge_index >> OFFSET_W;
			chunk_first <= job_edge_index[OFFSET_W-1:0];
			chunk_count <= first_count;
		end else if (chunk_go && remaining != '0) begin
			// Later chunks always start at offset zero
			chunk_line  <= chunk_line + 1'b1;
			chunk_first <= '0;
			chunk_count <= next_count;
		end
	end

	// Chunk held steady while the lanes are not ready
	assert property (@(posedge clock) disable iff (!rstn)
		chunk_valid && !chunk_ready |=> chunk_valid && $stable(chunk_line) &&
			$stable(chunk_first) && $stable(chunk_count));

endmodule

// File: rtl/edge_fetch_pkg.sv
/*
 * Edge fetch engine shared definitions
 *   cacheline and element geometry
 *   address, index, id and tag widths
 *   lane tag values and the output queue depth
 *   the packed edge record
 */

package edge_fetch_pkg;

	// Memory geometry
	localparam int LINE_BYTES     = 64;
	localparam int ELEM_BYTES     = 4;
	localparam int ELEMS_PER_LINE = LINE_BYTES / ELEM_BYTES;
	localparam int ELEM_W         = ELEM_BYTES * 8;
	localparam int LINE_W         = LINE_BYTES * 8;
	localparam int ADDR_W         = 32;

	// Index, id and tag widths
	localparam int INDEX_W  = 24;
	localparam int ID_W     = 16;
	localparam int TAG_W    = 2;
	localparam int OFFSET_W = $clog2(ELEMS_PER_LINE);
	localparam int COUNT_W  = OFFSET_W + 1;

	localparam int NUM_LANES       = 3;
	localparam int EDGE_FIFO_DEPTH = 8;

	typedef logic [ELEM_W-1:0]  elem_t;
	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [INDEX_W-1:0] edge_index_t;
	typedef logic [ID_W-1:0]    edge_id_t;
	typedef logic [TAG_W-1:0]   tag_t;

	// Element k sits at bits k*ELEM_W upward
	typedef logic [LINE_W-1:0] line_t;

	// One tag per array lane
	localparam tag_t LANE_SRC    = 2'd0;
	localparam tag_t LANE_DEST   = 2'd1;
	localparam tag_t LANE_WEIGHT = 2'd2;

	typedef struct packed {
		edge_id_t id;
		elem_t    src;
		elem_t    dest;
		elem_t    weight;
	} edge_t;

endpackage

// File: rtl/edge_fetch_top.sv
/*
 * Edge fetch engine top level
 *   chunk planner, three array lanes
 *   memory read arbiter and edge assembler
 */

`timescale 1ns/1ps

module edge_fetch_top (
	input  logic                        clock,
	input  logic                        rstn,
	input  edge_fetch_pkg::addr_t       src_base,
	input  edge_fetch_pkg::addr_t       dest_base,
	input  edge_fetch_pkg::addr_t       weight_base,
	input  logic                        job_valid,
	output logic                        job_ready,
	input  edge_fetch_pkg::edge_index_t job_edge_index,
	input  edge_fetch_pkg::edge_index_t job_degree,
	output logic                        mem_req_valid,
	input  logic                        mem_req_ready,
	output edge_fetch_pkg::addr_t       mem_req_addr,
	output edge_fetch_pkg::tag_t        mem_req_tag,
	input  logic                        mem_rsp_valid,
	input  edge_fetch_pkg::tag_t        mem_rsp_tag,
	input  edge_fetch_pkg::line_t       mem_rsp_data,
	output logic                        edge_valid,
	input  logic                        edge_ready,
	output edge_fetch_pkg::elem_t       edge_src,
	output edge_fetch_pkg::elem_t       edge_dest,
	output edge_fetch_pkg::elem_t       edge_weight,
	output edge_fetch_pkg::edge_id_t    edge_id
);

	import edge_fetch_pkg::*;

	logic                chunk_valid;
	logic                chunk_ready;
	logic                chunk_go;
	edge_index_t         chunk_line;
	logic [OFFSET_W-1:0] chunk_first;
	logic [COUNT_W-1:0]  chunk_count;

	logic [NUM_LANES-1:0] lane_chunk_ready;
	logic [NUM_LANES-1:0] lane_req_valid;
	logic [NUM_LANES-1:0] lane_req_ready;
	logic [NUM_LANES-1:0] lane_rsp_valid;
	logic [NUM_LANES-1:0] lane_elem_valid;
	logic                 elem_ready;
	addr_t                lane_req_addr [NUM_LANES];
	elem_t                lane_elem_data [NUM_LANES];
	addr_t                lane_base [NUM_LANES];

	assign lane_base[LANE_SRC]    = src_base;
	assign lane_base[LANE_DEST]   = dest_base;
	assign lane_base[LANE_WEIGHT] = weight_base;

	// Broadcast chunk moves only when every lane takes it
	assign chunk_ready = &lane_chunk_ready;
	assign chunk_go    = chunk_valid && chunk_ready;

	edge_chunk_planner planner_inst (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.job_edge_index(job_edge_index),
		.job_degree    (job_degree),
		.chunk_valid   (chunk_valid),
		.chunk_ready   (chunk_ready),
		.chunk_line    (chunk_line),
		.chunk_first   (chunk_first),
		.chunk_count   (chunk_count)
	);

	//////////////////////////////////////////////////
	// Lanes, indexed by their memory tag
	//////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		edge_array_lane #(
			.lane_tag(tag_t'(i))
		) lane_inst (
			.clock      (clock),
			.rstn       (rstn),
			.base_addr  (lane_base[i]),
			.chunk_valid(chunk_go),
			.chunk_ready(lane_chunk_ready[i]),
			.chunk_line (chunk_line),
			.chunk_first(chunk_first),
			.chunk_count(chunk_count),
			.req_valid  (lane_req_valid[i]),
			.req_ready  (lane_req_ready[i]),
			.req_addr   (lane_req_addr[i]),
			.rsp_valid  (lane_rsp_valid[i]),
			.rsp_data   (mem_rsp_data),
			.elem_valid (lane_elem_valid[i]),
			.elem_ready (elem_ready),
			.elem_data  (lane_elem_data[i])
		);
	end

	mem_read_arbiter arbiter_inst (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid    (lane_req_valid),
		.req_addr     (lane_req_addr),
		.req_ready    (lane_req_ready),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_addr (mem_req_addr),
		.mem_req_tag  (mem_req_tag),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_tag  (mem_rsp_tag),
		.rsp_valid    (lane_rsp_valid)
	);

	edge_assembler assembler_inst (
		.clock      (clock),
		.rstn       (rstn),
		.elem_valid (lane_elem_valid),
		.elem_data  (lane_elem_data),
		.elem_ready (elem_ready),
		.edge_valid (edge_valid),
		.edge_ready (edge_ready),
		.edge_src   (edge_src),
		.edge_dest  (edge_dest),
		.edge_weight(edge_weight),
		.edge_id    (edge_id)
	);

endmodule

// File: rtl/edge_sync_fifo.sv
/*
 * Synchronous FIFO
 *   register array storage, any payload type
 *   first-word fall-through read port
 *   overflow and underflow checks
 */

`timescale 1ns/1ps

module edge_sync_fifo #(
	parameter type         payload_t = logic,
	parameter int unsigned depth     = 4
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty
);

	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_w = $clog2(depth + 1);

	payload_t           mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;

	assign full     = (count == count_w'(depth));
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Writers and readers must respect the flags
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

// File: rtl/mem_read_arbiter.sv
/*
 * Memory read arbiter
 *   round-robin grant of the shared read port
 *   grant locked while a request stalls
 *   response routing by tag
 */

`timescale 1ns/1ps

module mem_read_arbiter (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic [edge_fetch_pkg::NUM_LANES-1:0] req_valid,
	input  edge_fetch_pkg::addr_t                req_addr [edge_fetch_pkg::NUM_LANES],
	output logic [edge_fetch_pkg::NUM_LANES-1:0] req_ready,
	output logic                                 mem_req_valid,
	input  logic                                 mem_req_ready,
	output edge_fetch_pkg::addr_t                mem_req_addr,
	output edge_fetch_pkg::tag_t                 mem_req_tag,
	input  logic                                 mem_rsp_valid,
	input  edge_fetch_pkg::tag_t                 mem_rsp_tag,
	output logic [edge_fetch_pkg::NUM_LANES-1:0] rsp_valid
);

	import edge_fetch_pkg::*;

	logic [NUM_LANES-1:0] grant;
	logic                 found;
	logic                 locked;
	tag_t                 rr_ptr;
	tag_t                 lock_idx;
	tag_t                 pick_idx;
	tag_t                 grant_idx;

	// First requester at or after the pointer
	always_comb begin
		int idx;
		found    = 1'b0;
		pick_idx = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			idx = (int'(rr_ptr) + k) % NUM_LANES;
			if (!found && req_valid[idx]) begin
				found    = 1'b1;
				pick_idx = tag_t'(idx);
			end
		end
	end

	assign grant_idx     = locked ? lock_idx : pick_idx;
	assign grant         = (locked || found) ? (NUM_LANES'(1) << grant_idx) : '0;
	assign mem_req_valid = |grant;
	assign mem_req_addr  = req_addr[grant_idx];
	assign mem_req_tag   = grant_idx;
	assign req_ready     = grant & {NUM_LANES{mem_req_ready}};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			locked   <= 1'b0;
			lock_idx <= '0;
			rr_ptr   <= '0;
		end else if (mem_req_valid && !mem_req_ready) begin
			locked   <= 1'b1;
			lock_idx <= grant_idx;
		end else begin
			locked <= 1'b0;
			if (mem_req_valid) begin
				rr_ptr <= (grant_idx == tag_t'(NUM_LANES - 1)) ? '0 : grant_idx + 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			rsp_valid[i] = mem_rsp_valid && (mem_rsp_tag == tag_t'(i));
		end
	end

	// Grant is one-hot or zero, and only ever to a lane that requests
	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(grant) && ((grant & ~req_valid) == '0));

endmodule
